// File: dmem_pkg.sv
/* shared types of the data-memory path, XLEN fixed at 32 and no sizes above word
   prot bit 2 is reserved for instruction fetches and is always zero here */
`default_nettype none

package dmem_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and constants
  ////////////////////////////////////////////////////////////////////////////
  localparam int XLEN           = 32;
  // request cycle to misaligned flag
  localparam int MISALIGN_DEPTH = 2;

  // privilege levels, only user and machine used
  localparam logic [1:0] PRV_U = 2'b00;
  localparam logic [1:0] PRV_M = 2'b11;

  // cfg register word offsets
  localparam logic [1:0] CFG_PRV_ADR    = 2'd0;
  localparam logic [1:0] CFG_UBASE_ADR  = 2'd1;
  localparam logic [1:0] CFG_ULIMIT_ADR = 2'd2;

  ////////////////////////////////////////////////////////////////////////////
  // transfer attributes
  ////////////////////////////////////////////////////////////////////////////
  // any other code is treated as misaligned
  typedef enum logic [2:0] {
    BYTE  = 3'b000,
    HWORD = 3'b001,
    WORD  = 3'b010
  } biu_size_t;

  typedef struct packed {
    logic instr;  // reserved for fetches
    logic priv;
    logic data;
  } biu_prot_t;

  ////////////////////////////////////////////////////////////////////////////
  // request, response and bus bundles
  ////////////////////////////////////////////////////////////////////////////
  // from the load/store unit
  typedef struct packed {
    logic [XLEN-1:0] adr;
    biu_size_t       size;
    logic            lock;
    logic            we;
    logic [XLEN-1:0] d;
  } mem_req_t;

  // core block toward the BIU
  typedef struct packed {
    logic [XLEN-1:0] adr;
    biu_size_t       size;
    logic            lock;
    logic            we;
    logic [XLEN-1:0] d;
    biu_prot_t       prot;
  } biu_req_t;

  typedef struct packed {
    logic [XLEN-1:0] q;
    logic            stb_ack;
    logic            ack;
    logic            err;
  } biu_rsp_t;

  // wishbone classic, master to slave
  typedef struct packed {
    logic            cyc;
    logic            stb;
    logic            we;
    logic [XLEN-1:0] adr;
    logic [XLEN-1:0] dat;
    logic [3:0]      sel;
    logic            lock;
  } wb_m2s_t;

  typedef struct packed {
    logic [XLEN-1:0] dat;
    logic            ack;
    logic            err;
  } wb_s2m_t;

endpackage

`default_nettype wire

// File: dmem_prv_cfg.sv
/* only adr[3:2] is decoded so the registers alias across the cfg space
   never errors, privilege written through byte lane 0 only */
`timescale 1ns/1ps
`default_nettype none

module dmem_prv_cfg
  import dmem_pkg::*;
(
  input  wire logic            clk_i,
  input  wire logic            rst_ni,
  input  wire wb_m2s_t         cfg_i,
  output wb_s2m_t              cfg_o,
  output logic [1:0]           prv_o,
  output logic [XLEN-1:0]      ubase_o,
  output logic [XLEN-1:0]      ulimit_o
);

  logic            access;
  logic            ack_q;
  logic [1:0]      idx;
  logic [1:0]      prv_q;
  logic [XLEN-1:0] ubase_q;
  logic [XLEN-1:0] ulimit_q;
  logic [XLEN-1:0] rdat_q;

  // byte lane merge for the window registers
  function automatic logic [XLEN-1:0] merge_bytes(input logic [XLEN-1:0] old_v,
                                                  input logic [XLEN-1:0] new_v,
                                                  input logic [3:0]      sel);
    logic [XLEN-1:0] res;
    res = old_v;
    for (int b = 0; b < 4; b++)
      if (sel[b])
        res[8*b +: 8] = new_v[8*b +: 8];
    return res;
  endfunction

  // one ack per strobe, the cycle after it rises
  assign access = cfg_i.cyc & cfg_i.stb & ~ack_q;
  assign idx    = cfg_i.adr[3:2];

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      ack_q    <= 1'b0;
      prv_q    <= PRV_M;
      ubase_q  <= '0;
      ulimit_q <= '0;
    end
    else
    begin
      ack_q <= access;
      if (access && cfg_i.we)
        case (idx)
          CFG_PRV_ADR:    if (cfg_i.sel[0]) prv_q <= cfg_i.dat[1:0];
          CFG_UBASE_ADR:  ubase_q  <= merge_bytes(ubase_q, cfg_i.dat, cfg_i.sel);
          CFG_ULIMIT_ADR: ulimit_q <= merge_bytes(ulimit_q, cfg_i.dat, cfg_i.sel);
          default:        ;
        endcase
    end
  end

  // read data, privilege zero extended
  always_ff @(posedge clk_i)
  begin
    if (access)
      case (idx)
        CFG_PRV_ADR:    rdat_q <= {{(XLEN-2){1'b0}}, prv_q};
        CFG_UBASE_ADR:  rdat_q <= ubase_q;
        CFG_ULIMIT_ADR: rdat_q <= ulimit_q;
        default:        rdat_q <= '0;
      endcase
  end

  assign cfg_o    = '{dat: rdat_q, ack: ack_q, err: 1'b0};
  assign prv_o    = prv_q;
  assign ubase_o  = ubase_q;
  assign ulimit_o = ulimit_q;

endmodule

`default_nettype wire

// File: dmem_nodcache_core.sv
/* LSU keeps mem_req_i and its fields stable until ack or err, one transfer in flight
   misaligned requests never reach the BIU and are flagged MISALIGN_DEPTH cycles later */
`timescale 1ns/1ps
`default_nettype none

module dmem_nodcache_core
  import dmem_pkg::*;
(
  input  wire logic            clk_i,
  input  wire logic            rst_ni,
  // load/store unit side
  input  wire logic            mem_req_i,
  input  wire mem_req_t        mem_i,
  output logic [XLEN-1:0]      mem_q_o,
  output logic                 mem_ack_o,
  output logic                 mem_err_o,
  output logic                 mem_misaligned_o,
  input  wire logic [1:0]      prv_i,
  // toward the BIU
  output logic                 biu_stb_o,
  output biu_req_t             biu_req_o,
  input  wire biu_rsp_t        biu_rsp_i
);

  logic                            misaligned;
  logic [MISALIGN_DEPTH-1:0]       misalign_q;
  logic                            hold_req_q;
  mem_req_t                        hold_mem_q;
  mem_req_t                        req_sel;
  biu_prot_t                       prot;
  logic [$clog2(MISALIGN_DEPTH):0] inflight_q;
  logic [$clog2(MISALIGN_DEPTH):0] discard_q;
  logic                            rsp_done;
  logic                            ack_fwd;
  logic                            err_fwd;

  ////////////////////////////////////////////////////////////////////////////
  // misalignment check
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    case (mem_i.size)
      BYTE:    misaligned = 1'b0;
      HWORD:   misaligned = mem_i.adr[0];
      WORD:    misaligned = |mem_i.adr[1:0];
      default: misaligned = 1'b1;
    endcase
    misaligned = misaligned & mem_req_i;
  end

  // delay line, last stage drives the flag
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      misalign_q <= '0;
    else
      misalign_q <= (misalign_q << 1) | MISALIGN_DEPTH'(misaligned);
  end

  assign mem_misaligned_o = misalign_q[MISALIGN_DEPTH-1];

  ////////////////////////////////////////////////////////////////////////////
  // request hold while the BIU is busy
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (mem_req_i)
      hold_mem_q <= mem_i;
  end

  // set while a strobe waits for stb_ack
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      hold_req_q <= 1'b0;
    else if (misaligned || err_fwd)
      hold_req_q <= 1'b0;
    else
      hold_req_q <= biu_stb_o & ~biu_rsp_i.stb_ack;
  end

  ////////////////////////////////////////////////////////////////////////////
  // in-flight and discard tracking
  ////////////////////////////////////////////////////////////////////////////
  assign rsp_done = biu_rsp_i.ack | biu_rsp_i.err;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      inflight_q <= '0;
    else
      case ({biu_rsp_i.stb_ack, rsp_done})
        2'b10:   inflight_q <= inflight_q + 1'b1;
        2'b01:   inflight_q <= inflight_q - 1'b1;
        default: ;
      endcase
  end

  // responses still owed to an abandoned request are dropped
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      discard_q <= '0;
    else if (misaligned || err_fwd)
    begin
      if (|inflight_q && rsp_done)
        discard_q <= inflight_q - 1'b1;
      else
        discard_q <= inflight_q;
    end
    else if (|discard_q && rsp_done)
      discard_q <= discard_q - 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // BIU request and LSU response
  ////////////////////////////////////////////////////////////////////////////
  assign req_sel = hold_req_q ? hold_mem_q : mem_i;

  // user or privileged data access, never a fetch
  assign prot = '{instr: 1'b0, priv: (prv_i != PRV_U), data: 1'b1};

  // no new strobe until the previous transfer completes
  assign biu_stb_o = (mem_req_i | hold_req_q) & ~misaligned & ~|inflight_q;

  assign biu_req_o = '{adr:  req_sel.adr,
                       size: req_sel.size,
                       lock: req_sel.lock,
                       we:   req_sel.we,
                       d:    req_sel.d,
                       prot: prot};

  // zero-wait completion arrives together with stb_ack
  assign ack_fwd = |inflight_q ? biu_rsp_i.ack : biu_rsp_i.ack & biu_stb_o;
  assign err_fwd = ~|discard_q & (|inflight_q ? biu_rsp_i.err : biu_rsp_i.err & biu_stb_o);

  assign mem_q_o   = biu_rsp_i.q;
  assign mem_ack_o = ~|discard_q & ack_fwd;
  assign mem_err_o = err_fwd;

  // BIU accepts only a live strobe
  stb_ack_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    biu_rsp_i.stb_ack |-> biu_stb_o);

  // a completion without acceptance needs an earlier accepted transfer
  inflight_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rsp_done && !biu_rsp_i.stb_ack) |-> (inflight_q != '0));

endmodule

`default_nettype wire

// File: dmem_biu_wb.sv
/* single outstanding Wishbone classic cycle, user window is [ubase, ulimit)
   ulimit at or below ubase faults every user access */
`timescale 1ns/1ps
`default_nettype none

module dmem_biu_wb
  import dmem_pkg::*;
(
  input  wire logic            clk_i,
  input  wire logic            rst_ni,
  input  wire logic            biu_stb_i,
  input  wire biu_req_t        biu_req_i,
  output biu_rsp_t             biu_rsp_o,
  input  wire logic [XLEN-1:0] ubase_i,
  input  wire logic [XLEN-1:0] ulimit_i,
  output wb_m2s_t              wb_o,
  input  wire wb_s2m_t         wb_i
);

  typedef enum logic [1:0] {ST_IDLE, ST_BUS, ST_FAULT} state_t;

  state_t          state_q;
  logic            accept;
  logic            window_err;
  logic            acc_q;
  logic            in_bus;
  logic [3:0]      sel_d;
  logic [XLEN-1:0] adr_q;
  logic [XLEN-1:0] dat_q;
  logic [3:0]      sel_q;
  logic            we_q;
  logic            lock_q;
  biu_size_t       size_q;
  logic [1:0]      lane_q;
  logic [XLEN-1:0] rd_shift;
  logic [XLEN-1:0] rd_data;

  assign accept = (state_q == ST_IDLE) & biu_stb_i;

  // privileged accesses skip the window
  assign window_err = ~biu_req_i.prot.priv &
                      ((biu_req_i.adr < ubase_i) | (biu_req_i.adr >= ulimit_i));

  // byte lanes from size and low address
  always_comb
  begin
    case (biu_req_i.size)
      BYTE:    sel_d = 4'b0001 << biu_req_i.adr[1:0];
      HWORD:   sel_d = 4'b0011 << {biu_req_i.adr[1], 1'b0};
      WORD:    sel_d = 4'b1111;
      default: sel_d = 4'b0000;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= ST_IDLE;
      acc_q   <= 1'b0;
    end
    else
    begin
      // stb_ack for a bus cycle lines up with the rising wb stb
      acc_q <= accept & ~window_err;
      case (state_q)
        ST_IDLE:  if (biu_stb_i) state_q <= window_err ? ST_FAULT : ST_BUS;
        ST_BUS:   if (wb_i.ack || wb_i.err) state_q <= ST_IDLE;
        default:  state_q <= ST_IDLE;
      endcase
    end
  end

  // transfer payload, word aligned address
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      adr_q  <= {biu_req_i.adr[XLEN-1:2], 2'b00};
      dat_q  <= biu_req_i.d << {biu_req_i.adr[1:0], 3'b000};
      sel_q  <= sel_d;
      we_q   <= biu_req_i.we;
      lock_q <= biu_req_i.lock;
      size_q <= biu_req_i.size;
      lane_q <= biu_req_i.adr[1:0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus outputs and read alignment
  ////////////////////////////////////////////////////////////////////////////
  assign in_bus = (state_q == ST_BUS);

  assign wb_o = '{cyc: in_bus, stb: in_bus, we: we_q, adr: adr_q,
                  dat: dat_q, sel: sel_q, lock: lock_q};

  // move the addressed lane down, then zero extend
  assign rd_shift = wb_i.dat >> {lane_q, 3'b000};

  always_comb
  begin
    case (size_q)
      BYTE:    rd_data = {{(XLEN-8){1'b0}}, rd_shift[7:0]};
      HWORD:   rd_data = {{(XLEN-16){1'b0}}, rd_shift[15:0]};
      default: rd_data = rd_shift;
    endcase
  end

  assign biu_rsp_o = '{q:       rd_data,
                       stb_ack: (accept & window_err) | acc_q,
                       ack:     in_bus & wb_i.ack,
                       err:     (in_bus & wb_i.err) | (state_q == ST_FAULT)};

  // classic cycle holds strobe and address until the slave answers
  wb_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_o.stb && !wb_i.ack && !wb_i.err) |=>
      (wb_o.stb && wb_o.cyc && $stable(wb_o.adr)));

endmodule

`default_nettype wire

// File: dmem_subsys_top.sv
/* data-memory subsystem without cache, the cfg port is a separate Wishbone slave
   the data bus runs one classic cycle at a time */
`timescale 1ns/1ps
`default_nettype none

module dmem_subsys_top
  import dmem_pkg::*;
(
  input  wire logic            clk_i,
  input  wire logic            rst_ni,
  // load/store unit
  input  wire logic            mem_req_i,
  input  wire mem_req_t        mem_i,
  output logic [XLEN-1:0]      mem_q_o,
  output logic                 mem_ack_o,
  output logic                 mem_err_o,
  output logic                 mem_misaligned_o,
  // configuration slave
  input  wire wb_m2s_t         cfg_i,
  output wb_s2m_t              cfg_o,
  // data bus master
  output wb_m2s_t              wb_o,
  input  wire wb_s2m_t         wb_i
);

  logic [1:0]      prv;
  logic [XLEN-1:0] ubase;
  logic [XLEN-1:0] ulimit;
  logic            biu_stb;
  biu_req_t        biu_req;
  biu_rsp_t        biu_rsp;

  // privilege and user window
  dmem_prv_cfg dmem_prv_cfg_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .cfg_i    (cfg_i),
    .cfg_o    (cfg_o),
    .prv_o    (prv),
    .ubase_o  (ubase),
    .ulimit_o (ulimit)
  );

  dmem_nodcache_core dmem_nodcache_core_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .mem_req_i        (mem_req_i),
    .mem_i            (mem_i),
    .mem_q_o          (mem_q_o),
    .mem_ack_o        (mem_ack_o),
    .mem_err_o        (mem_err_o),
    .mem_misaligned_o (mem_misaligned_o),
    .prv_i            (prv),
    .biu_stb_o        (biu_stb),
    .biu_req_o        (biu_req),
    .biu_rsp_i        (biu_rsp)
  );

  dmem_biu_wb dmem_biu_wb_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .biu_stb_i (biu_stb),
    .biu_req_i (biu_req),
    .biu_rsp_o (biu_rsp),
    .ubase_i   (ubase),
    .ulimit_i  (ulimit),
    .wb_o      (wb_o),
    .wb_i      (wb_i)
  );

endmodule

`default_nettype wire

// File: tb_wb_mem.sv
/* 256-word Wishbone classic memory, only adr[9:2] decoded so it aliases every 1 KiB
   never raises err, waits_i must stay stable while a cycle is open */
`timescale 1ns/1ps
`default_nettype none

module tb_wb_mem
  import dmem_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire logic [3:0] waits_i,
  input  wire wb_m2s_t    wb_i,
  output wb_s2m_t         wb_o
);

  logic [XLEN-1:0] mem [256];
  logic [3:0]      cnt_q;
  logic            req;
  logic            ack;
  logic [7:0]      idx;
  logic [XLEN-1:0] wr_word;

  // fill pattern, every byte depends on the full word index
  initial
  begin
    for (int i = 0; i < 256; i++)
      mem[i] = {8'(i) ^ 8'hc3, ~8'(i), 8'(i) + 8'h35, 8'(i)};
  end

  assign idx = wb_i.adr[9:2];
  assign req = wb_i.cyc & wb_i.stb;
  // zero waits acks in the cycle stb rises
  assign ack = req & (cnt_q == waits_i);

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      cnt_q <= '0;
    else if (ack)
      cnt_q <= '0;
    else if (req)
      cnt_q <= cnt_q + 1'b1;
  end

  // merge selected byte lanes into the stored word
  always_comb
  begin
    wr_word = mem[idx];
    for (int b = 0; b < 4; b++)
      if (wb_i.sel[b])
        wr_word[8*b +: 8] = wb_i.dat[8*b +: 8];
  end

  always @(posedge clk_i)
  begin
    if (ack && wb_i.we)
      mem[idx] <= wr_word;
  end

  assign wb_o = '{dat: mem[idx], ack: ack, err: 1'b0};

endmodule

`default_nettype wire

// File: tb_dmem_subsys.sv
/* drives the LSU and cfg ports one request at a time against a shadow memory
   only adr[9:2] reaches the memory model while upper bits matter for the user window */
`timescale 1ns/1ps
`default_nettype none

module tb_dmem_subsys
  import dmem_pkg::*;
();

  typedef enum logic [1:0] {RES_ACK, RES_ERR, RES_MIS} res_kind_t;

  typedef struct packed {
    res_kind_t       kind;
    logic [XLEN-1:0] q;
  } exp_t;

  localparam int TIMEOUT = 64;

  logic            clk_i;
  logic            rst_ni;
  logic            mem_req;
  mem_req_t        mem_in;
  logic [XLEN-1:0] mem_q;
  logic            mem_ack;
  logic            mem_err;
  logic            mem_mis;
  wb_m2s_t         cfg_m2s;
  wb_s2m_t         cfg_s2m;
  wb_m2s_t         wb_m2s;
  wb_s2m_t         wb_s2m;
  logic [3:0]      mem_waits;

  // tb view of the design state
  logic [XLEN-1:0] shadow [256];
  logic [1:0]      prv_t;
  logic [XLEN-1:0] ubase_t;
  logic [XLEN-1:0] ulimit_t;
  logic [15:0]     lfsr_state;
  exp_t            exp_res;
  logic            exp_we;
  logic            exp_lock;
  logic            exp_valid;
  logic            cyc_prev;
  int              err_cnt;
  int              tmo_cnt;
  int              done_cnt;
  int              bus_starts;

  ////////////////////////////////////////////////////////////////////////////
  // clock, DUT and memory model
  ////////////////////////////////////////////////////////////////////////////
  initial
  begin
    clk_i = 1'b0;
  end

  always #2 clk_i = ~clk_i;

  dmem_subsys_top dmem_subsys_top_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .mem_req_i        (mem_req),
    .mem_i            (mem_in),
    .mem_q_o          (mem_q),
    .mem_ack_o        (mem_ack),
    .mem_err_o        (mem_err),
    .mem_misaligned_o (mem_mis),
    .cfg_i            (cfg_m2s),
    .cfg_o            (cfg_s2m),
    .wb_o             (wb_m2s),
    .wb_i             (wb_s2m)
  );

  tb_wb_mem tb_wb_mem_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .waits_i (mem_waits),
    .wb_i    (wb_m2s),
    .wb_o    (wb_s2m)
  );

  ////////////////////////////////////////////////////////////////////////////
  // random numbers and reference model
  ////////////////////////////////////////////////////////////////////////////
  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one step per bit taken
  function automatic logic [XLEN-1:0] rand_bits(input int n);
    logic [XLEN-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[XLEN-2:0], lfsr_state[15]};
    end
    return v;
  endfunction

  // same fill as the memory model
  function automatic logic [XLEN-1:0] fill_word(input int i);
    return {8'(i) ^ 8'hc3, ~8'(i), 8'(i) + 8'h35, 8'(i)};
  endfunction

  function automatic mem_req_t make_req(input logic [XLEN-1:0] adr, input biu_size_t size,
                                        input logic we, input logic [XLEN-1:0] d);
    mem_req_t r;
    r.adr  = adr;
    r.size = size;
    r.lock = 1'b0;
    r.we   = we;
    r.d    = d;
    return r;
  endfunction

  // misaligned first then the user window and otherwise a normal access
  function automatic exp_t ref_access(input mem_req_t r, input logic [1:0] prv,
                                      input logic [XLEN-1:0] ubase,
                                      input logic [XLEN-1:0] ulimit);
    exp_t            e;
    logic [XLEN-1:0] lane;
    logic            mis;
    lane = shadow[r.adr[9:2]] >> (8 * r.adr[1:0]);
    case (r.size)
      BYTE:
      begin
        mis = 1'b0;
        e.q = lane & 32'h0000_00ff;
      end
      HWORD:
      begin
        mis = r.adr[0];
        e.q = lane & 32'h0000_ffff;
      end
      WORD:
      begin
        mis = (r.adr[1:0] != 2'b00);
        e.q = lane;
      end
      default:
      begin
        mis = 1'b1;
        e.q = '0;
      end
    endcase
    if (mis)
      e.kind = RES_MIS;
    else if (prv == PRV_U && (r.adr < ubase || r.adr >= ulimit))
      e.kind = RES_ERR;
    else
      e.kind = RES_ACK;
    return e;
  endfunction

  // completed write lands in its byte lanes
  task automatic apply_write(input mem_req_t r);
    logic [3:0]      sel;
    logic [XLEN-1:0] d;
    case (r.size)
      BYTE:    sel = 4'b0001 << r.adr[1:0];
      HWORD:   sel = 4'b0011 << r.adr[1:0];
      default: sel = 4'b1111;
    endcase
    d = r.d << (8 * r.adr[1:0]);
    for (int b = 0; b < 4; b++)
      if (sel[b])
        shadow[r.adr[9:2]][8*b +: 8] = d[8*b +: 8];
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_data(input string what, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_size(input biu_size_t got, input biu_size_t exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("Error at %0t: BIU size is %0d, expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_prot(input biu_prot_t got, input biu_prot_t exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("Error at %0t: BIU prot is %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_result(input res_kind_t got, input res_kind_t exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("Error at %0t: result kind is %0d, expected %0d", $time, got, exp);
    end
  endtask

  task automatic timeout_hit(input string what);
    tmo_cnt++;
    $display("Timeout: no %s within %0d cycles at %0t", what, TIMEOUT, $time);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // monitors sample at the falling edge where outputs are stable
  ////////////////////////////////////////////////////////////////////////////
  always @(negedge clk_i)
  begin
    if (rst_ni && (mem_ack || mem_err || mem_mis))
    begin
      done_cnt++;
      if (!exp_valid)
      begin
        err_cnt++;
        $display("Error at %0t: completion with no request outstanding", $time);
      end
      else
      begin
        exp_valid = 1'b0;
        check_result(mem_mis ? RES_MIS : (mem_err ? RES_ERR : RES_ACK), exp_res.kind);
        if (mem_ack && !exp_we)
          check_data("read data", mem_q, exp_res.q);
      end
    end
  end

  // rising cyc starts a bus cycle carrying the request's lock bit
  always @(negedge clk_i)
  begin
    if (rst_ni && wb_m2s.cyc && !cyc_prev)
    begin
      bus_starts++;
      check_data("wb lock", XLEN'(wb_m2s.lock), XLEN'(exp_lock));
    end
    cyc_prev = wb_m2s.cyc;
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////////////////////////////
  task automatic cfg_access(input logic we, input logic [1:0] idx,
                            input logic [XLEN-1:0] wdat, output logic [XLEN-1:0] rdat);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    rdat = '0;
    @(posedge clk_i);
    #1;
    cfg_m2s = '{cyc: 1'b1, stb: 1'b1, we: we, adr: {{(XLEN-4){1'b0}}, idx, 2'b00},
                dat: wdat, sel: 4'hf, lock: 1'b0};
    while (!seen && n < TIMEOUT)
    begin
      @(negedge clk_i);
      // the cfg slave never errors
      check_data("cfg err", XLEN'(cfg_s2m.err), '0);
      if (cfg_s2m.ack)
      begin
        seen = 1'b1;
        rdat = cfg_s2m.dat;
      end
      n++;
    end
    @(posedge clk_i);
    #1;
    cfg_m2s = '0;
    if (!seen)
      timeout_hit("cfg ack");
  endtask

  // tb copies follow the register rules with privilege kept to 2 bits
  task automatic cfg_write(input logic [1:0] idx, input logic [XLEN-1:0] wdat);
    logic [XLEN-1:0] dummy;
    cfg_access(1'b1, idx, wdat, dummy);
    case (idx)
      CFG_PRV_ADR:    prv_t = wdat[1:0];
      CFG_UBASE_ADR:  ubase_t = wdat;
      CFG_ULIMIT_ADR: ulimit_t = wdat;
      default:        ;
    endcase
  endtask

  task automatic cfg_read(input logic [1:0] idx);
    logic [XLEN-1:0] rdat;
    cfg_access(1'b0, idx, '0, rdat);
    case (idx)
      CFG_PRV_ADR:    check_data("cfg prv", rdat, {{(XLEN-2){1'b0}}, prv_t});
      CFG_UBASE_ADR:  check_data("cfg ubase", rdat, ubase_t);
      default:        check_data("cfg ulimit", rdat, ulimit_t);
    endcase
  endtask

  // one LSU request held until it ends or withdrawn after one misaligned cycle
  task automatic do_access(input mem_req_t r, input logic [3:0] waits);
    exp_t      e;
    biu_prot_t prot_exp;
    int        n;
    int        starts0;
    int        done0;
    logic      seen;
    e        = ref_access(r, prv_t, ubase_t, ulimit_t);
    // bit 0 data, bit 1 privileged, bit 2 never set
    prot_exp = (prv_t == PRV_U) ? 3'b001 : 3'b011;
    starts0  = bus_starts;
    done0    = done_cnt;
    seen     = 1'b0;
    @(posedge clk_i);
    #1;
    exp_res   = e;
    exp_we    = r.we;
    exp_lock  = r.lock;
    exp_valid = 1'b1;
    mem_waits = waits;
    mem_in    = r;
    mem_req   = 1'b1;
    if (e.kind == RES_MIS)
    begin
      @(posedge clk_i);
      #1;
      mem_req = 1'b0;
      n = 1;
      while (!seen && n <= TIMEOUT)
      begin
        @(negedge clk_i);
        if (mem_mis)
          seen = 1'b1;
        else
          n++;
      end
      if (!seen)
        timeout_hit("misaligned flag");
      else if (n != MISALIGN_DEPTH)
      begin
        err_cnt++;
        $display("Error at %0t: misaligned flag after %0d cycles, expected %0d",
                 $time, n, MISALIGN_DEPTH);
      end
    end
    else
    begin
      n = 0;
      while (!seen && n < TIMEOUT)
      begin
        @(negedge clk_i);
        // request cycle shows the attributes toward the BIU
        if (n == 0)
        begin
          check_size(dmem_subsys_top_inst.biu_req.size, r.size);
          check_prot(dmem_subsys_top_inst.biu_req.prot, prot_exp);
        end
        if (mem_ack || mem_err)
          seen = 1'b1;
        n++;
      end
      @(posedge clk_i);
      #1;
      mem_req = 1'b0;
      if (!seen)
        timeout_hit("request completion");
    end
    // late or repeated responses would show in this settle window
    repeat (2) @(posedge clk_i);
    #1;
    if (bus_starts != starts0 + ((e.kind == RES_ACK) ? 1 : 0))
    begin
      err_cnt++;
      $display("Error at %0t: %0d bus cycles started for one request", $time,
               bus_starts - starts0);
    end
    if (done_cnt != done0 + 1)
    begin
      err_cnt++;
      $display("Error at %0t: %0d completions for one request", $time, done_cnt - done0);
    end
    if (e.kind == RES_ACK && r.we)
      apply_write(r);
  endtask

  function automatic logic [XLEN-1:0] align_adr(input logic [XLEN-1:0] adr,
                                                input biu_size_t size);
    case (size)
      BYTE:    return adr;
      HWORD:   return {adr[XLEN-1:1], 1'b0};
      default: return {adr[XLEN-1:2], 2'b00};
    endcase
  endfunction

  // write then read back at the same size and then the whole word
  task automatic write_read(input logic [3:0] wmin, input int wbits);
    biu_size_t       sz;
    logic [XLEN-1:0] adr;
    logic [XLEN-1:0] d;
    mem_req_t        wr;
    sz  = biu_size_t'(rand_bits(2) % 3);
    adr = align_adr(rand_bits(10), sz);
    d   = rand_bits(32);
    // some writes go out locked
    wr      = make_req(adr, sz, 1'b1, d);
    wr.lock = (rand_bits(1) != '0);
    do_access(wr, wmin + 4'(rand_bits(wbits)));
    do_access(make_req(adr, sz, 1'b0, '0), wmin + 4'(rand_bits(wbits)));
    do_access(make_req(align_adr(adr, WORD), WORD, 1'b0, '0), wmin + 4'(rand_bits(wbits)));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // scenarios
  ////////////////////////////////////////////////////////////////////////////
  initial
  begin
    rst_ni     = 1'b0;
    mem_req    = 1'b0;
    mem_in     = '0;
    cfg_m2s    = '0;
    mem_waits  = '0;
    exp_res    = '0;
    exp_we     = 1'b0;
    exp_lock   = 1'b0;
    exp_valid  = 1'b0;
    cyc_prev   = 1'b0;
    err_cnt    = 0;
    tmo_cnt    = 0;
    done_cnt   = 0;
    bus_starts = 0;
    lfsr_state = 16'd11860;
    prv_t      = PRV_M;
    ubase_t    = '0;
    ulimit_t   = '0;
    for (int i = 0; i < 256; i++)
      shadow[i] = fill_word(i);
    @(negedge clk_i);
    @(negedge clk_i);
    // outputs quiet while in reset
    check_data("outputs in reset", {26'b0, mem_ack, mem_err, mem_mis, wb_m2s.cyc,
               wb_m2s.stb, cfg_s2m.ack}, '0);
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // privilege leaves reset in machine mode
    cfg_read(CFG_PRV_ADR);

    // register read back with the privilege masked
    cfg_write(CFG_UBASE_ADR, 32'h0000_0100);
    cfg_write(CFG_ULIMIT_ADR, 32'h0000_0200);
    cfg_write(CFG_PRV_ADR, 32'hffff_fffd);
    cfg_read(CFG_UBASE_ADR);
    cfg_read(CFG_ULIMIT_ADR);
    cfg_read(CFG_PRV_ADR);
    cfg_write(CFG_PRV_ADR, {{(XLEN-2){1'b0}}, PRV_M});
    cfg_read(CFG_PRV_ADR);

    // machine mode with 0 to 3 wait states
    for (int k = 0; k < 12; k++)
      write_read(4'd0, 2);

    // misaligned requests where the last one uses an unused size code
    do_access(make_req(32'h0000_0041, HWORD, 1'b0, '0), 4'd0);
    do_access(make_req(32'h0000_0082, WORD, 1'b1, 32'hdead_beef), 4'd0);
    do_access(make_req(32'h0000_0083, WORD, 1'b0, '0), 4'd0);
    do_access(make_req(32'h0000_0040, biu_size_t'(3'b011), 1'b0, '0), 4'd0);

    // user mode inside and outside [0x100, 0x200)
    cfg_write(CFG_PRV_ADR, {{(XLEN-2){1'b0}}, PRV_U});
    do_access(make_req(32'h0000_0104, WORD, 1'b1, 32'h1234_5678), 4'd1);
    do_access(make_req(32'h0000_0104, WORD, 1'b0, '0), 4'd2);
    do_access(make_req(32'h0000_01fe, HWORD, 1'b0, '0), 4'd0);
    do_access(make_req(32'h0000_01ff, BYTE, 1'b1, 32'h0000_00a5), 4'd3);
    do_access(make_req(32'h0000_00fc, WORD, 1'b0, '0), 4'd0);
    do_access(make_req(32'h0000_0200, BYTE, 1'b1, 32'h0000_0077), 4'd0);
    do_access(make_req(32'h8000_0100, WORD, 1'b0, '0), 4'd0);
    do_access(make_req(32'h0000_0101, HWORD, 1'b0, '0), 4'd0);
    cfg_write(CFG_PRV_ADR, {{(XLEN-2){1'b0}}, PRV_M});
    do_access(make_req(32'h0000_00fc, WORD, 1'b0, '0), 4'd0);

    // back-pressure with 8 to 15 wait states
    for (int k = 0; k < 6; k++)
      write_read(4'd8, 3);

    $display("errors: %0d, timeouts: %0d, completions: %0d", err_cnt, tmo_cnt, done_cnt);
    if (err_cnt == 0 && tmo_cnt == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
dmem_pkg.sv
dmem_prv_cfg.sv
dmem_nodcache_core.sv
dmem_biu_wb.sv
dmem_subsys_top.sv
tb_wb_mem.sv
tb_dmem_subsys.sv

// File: Bender.yml
package:
  name: dmem_subsys

sources:
  - dmem_pkg.sv
  - dmem_prv_cfg.sv
  - dmem_nodcache_core.sv
  - dmem_biu_wb.sv
  - dmem_subsys_top.sv
  - target: test
    files:
      - tb_wb_mem.sv
      - tb_dmem_subsys.sv
